/* verilog/spriteGeomPkg.sv */
`default_nettype none

package spriteGeomPkg;

   localparam int spriteSide = 128;                // frame width and height in pixels
   localparam int sideBits   = $clog2(spriteSide); // one row or column index
   localparam int addrBits   = 2 * sideBits;       // 14 bits for a whole frame
   localparam int coordBits  = 10;                 // beam and sprite position
   localparam int frameDepth = 1 << addrBits;      // 16K pixels per frame

   typedef struct packed {
      logic [sideBits-1:0] row;
      logic [sideBits-1:0] col;
   } pixelRc_t;

   // same 14 bits read as a memory index or as row and column
   typedef union packed {
      logic [addrBits-1:0] linear;
      pixelRc_t            rc;
   } pixelAddr_u;

endpackage

`default_nettype wire

/* verilog/spriteRegPkg.sv */
`default_nettype none

package spriteRegPkg;

   localparam int apbAddrBits = 8;
   localparam int apbDataBits = 32;

   localparam logic [apbAddrBits-1:0] regCtrl    = 8'h00;
   localparam logic [apbAddrBits-1:0] regPos     = 8'h04;
   localparam logic [apbAddrBits-1:0] regPixAddr = 8'h08;
   localparam logic [apbAddrBits-1:0] regPixData = 8'h0C; // write only

   localparam int ctrlWidth     = 16;                      // used bits of regCtrl
   localparam int ctrlEnBit     = 0;
   localparam int ctrlAutoBit   = 1;
   localparam int ctrlSelLsb    = 4;
   localparam int frameSelWidth = 2;
   localparam int ctrlPeriodLsb = 8;
   localparam int periodWidth   = ctrlWidth - ctrlPeriodLsb;

   localparam int posWidth = 10;                           // posX and posY
   localparam int posXLsb  = 0;
   localparam int posYLsb  = 16;

   localparam int pixColLsb   = 0;
   localparam int pixRowLsb   = 7;
   localparam int pixFrameLsb = 16;
   localparam int pixDataBit  = 0;                         // pixel value in regPixData

endpackage

`default_nettype wire

/* verilog/frameStore.sv */
`timescale 1ns/1ps
`default_nettype none

module frameStore (
   input  wire                             clk,
   input  wire                             rdEn,
   input  wire spriteGeomPkg::pixelAddr_u  rdAddr,
   input  wire                             wrEn,
   input  wire spriteGeomPkg::pixelAddr_u  wrAddr,
   input  wire                             wrData,
   output logic                            pixel
);
   import spriteGeomPkg::*;

   logic mem [frameDepth];      // one bit per sprite pixel
   logic collide;

   assign collide = wrEn && (wrAddr.linear == rdAddr.linear);

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr.linear] <= wrData;
      end
   end

   // registered read port, output holds while rdEn is low
   always_ff @(posedge clk) begin
      if (rdEn) begin
         if (collide) begin
            pixel <= wrData;     // write first on the same address
         end else begin
            pixel <= mem[rdAddr.linear];
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/frameScanner.sv */
`timescale 1ns/1ps
`default_nettype none

module frameScanner (
   input  wire                                 clk,
   input  wire                                 rst,
   input  wire  [spriteGeomPkg::coordBits-1:0] beamX,
   input  wire  [spriteGeomPkg::coordBits-1:0] beamY,
   input  wire                                 beamValid,
   input  wire  [spriteGeomPkg::coordBits-1:0] posX,
   input  wire  [spriteGeomPkg::coordBits-1:0] posY,
   output spriteGeomPkg::pixelAddr_u           rdAddr,
   output logic                                rdEn,
   output logic                                inBounds,
   output logic                                validOut
);
   import spriteGeomPkg::*;

   logic [coordBits:0] diffX;   // top bit set when the beam is left of the sprite
   logic [coordBits:0] diffY;   // top bit set when the beam is above the sprite
   logic               hitX;
   logic               hitY;
   logic               hit;

   assign diffX = {1'b0, beamX} - {1'b0, posX};
   assign diffY = {1'b0, beamY} - {1'b0, posY};

   assign hitX = !diffX[coordBits] && (diffX[coordBits-1:0] < spriteSide);
   assign hitY = !diffY[coordBits] && (diffY[coordBits-1:0] < spriteSide);
   assign hit  = hitX && hitY;

   always_ff @(posedge clk) begin
      if (rst) begin
         rdEn     <= 1'b0;
         inBounds <= 1'b0;
         validOut <= 1'b0;
      end else begin
         rdEn     <= beamValid && hit;   // memory only reads inside the box
         inBounds <= hit;
         validOut <= beamValid;
      end
   end

   // low bits of the offsets are the sprite row and column
   always_ff @(posedge clk) begin
      rdAddr.rc.row <= diffY[sideBits-1:0];
      rdAddr.rc.col <= diffX[sideBits-1:0];
   end

endmodule

`default_nettype wire

/* verilog/spriteOutput.sv */
`timescale 1ns/1ps
`default_nettype none

module spriteOutput #(
   parameter int numFrames = 4
) (
   input  wire                                    clk,
   input  wire                                    rst,
   input  wire  [numFrames-1:0]                   framePixels,
   input  wire  [spriteRegPkg::frameSelWidth-1:0] activeFrame,
   input  wire                                    enable,
   input  wire                                    inBounds,
   input  wire                                    validIn,
   output logic                                   pixelOn,
   output logic                                   pixelValid
);

   logic inBoundsDly;   // lines up with the frame store output
   logic validDly;
   logic selPixel;

   assign selPixel = framePixels[activeFrame];

   always_ff @(posedge clk) begin
      if (rst) begin
         inBoundsDly <= 1'b0;
         validDly    <= 1'b0;
      end else begin
         inBoundsDly <= inBounds;
         validDly    <= validIn;
      end
   end

   // frame select and enable act on whatever sample is in this stage
   always_ff @(posedge clk) begin
      if (rst) begin
         pixelOn    <= 1'b0;
         pixelValid <= 1'b0;
      end else begin
         pixelOn    <= validDly && inBoundsDly && enable && selPixel;
         pixelValid <= validDly;
      end
   end

endmodule

`default_nettype wire

/* verilog/spriteApbRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module spriteApbRegs #(
   parameter int numFrames = 4
) (
   input  wire                                     clk,
   input  wire                                     rst,
   input  wire                                     psel,
   input  wire                                     penable,
   input  wire                                     pwrite,
   input  wire  [spriteRegPkg::apbAddrBits-1:0]    paddr,
   input  wire  [spriteRegPkg::apbDataBits-1:0]    pwdata,
   input  wire                                     frameStart,
   output logic [spriteRegPkg::apbDataBits-1:0]    prdata,
   output logic                                    pready,
   output logic                                    pslverr,
   output logic [spriteGeomPkg::coordBits-1:0]     posX,
   output logic [spriteGeomPkg::coordBits-1:0]     posY,
   output logic                                    enable,
   output logic [spriteRegPkg::frameSelWidth-1:0]  activeFrame,
   output spriteGeomPkg::pixelAddr_u               wrAddr,
   output logic                                    wrData,
   output logic [numFrames-1:0]                    wrEn
);
   import spriteGeomPkg::*;
   import spriteRegPkg::*;

   logic                     access;
   logic                     addrHit;
   logic                     selBad;
   logic                     pixFrameBad;
   logic                     wrAccess;
   logic                     pixWrite;
   logic                     autoAnimate;
   logic [frameSelWidth-1:0] frameSel;
   logic [periodWidth-1:0]   period;
   logic [frameSelWidth-1:0] pixFrame;
   logic [frameSelWidth-1:0] animFrame;
   logic [periodWidth-1:0]   animCount;
   logic [periodWidth-1:0]   animNext;

   assign access  = psel && penable;
   assign addrHit = paddr inside {regCtrl, regPos, regPixAddr, regPixData};

   // frame indices beyond the instantiated stores are refused
   assign selBad      = (paddr == regCtrl) && (pwdata[ctrlSelLsb +: frameSelWidth] >= numFrames);
   assign pixFrameBad = (paddr == regPixAddr) &&
                        (pwdata[pixFrameLsb +: frameSelWidth] >= numFrames);

   assign pready   = access;                        // no wait states
   assign pslverr  = access && (!addrHit || (pwrite && (selBad || pixFrameBad)));
   assign wrAccess = access && pwrite && !pslverr;
   assign pixWrite = wrAccess && (paddr == regPixData);

   assign wrData = pwdata[pixDataBit];

   always_comb begin
      for (int f = 0; f < numFrames; f++) begin
         wrEn[f] = pixWrite && (pixFrame == f); // one hot on the addressed frame
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         enable      <= 1'b0;
         autoAnimate <= 1'b0;
         frameSel    <= '0;
         period      <= '0;
         posX        <= '0;
         posY        <= '0;
         wrAddr      <= '0;
         pixFrame    <= '0;
      end else if (wrAccess) begin
         case (paddr)
            regCtrl: begin
               enable      <= pwdata[ctrlEnBit];
               autoAnimate <= pwdata[ctrlAutoBit];
               frameSel    <= pwdata[ctrlSelLsb +: frameSelWidth];
               period      <= pwdata[ctrlPeriodLsb +: periodWidth];
            end
            regPos: begin
               posX <= pwdata[posXLsb +: posWidth];
               posY <= pwdata[posYLsb +: posWidth];
            end
            regPixAddr: begin
               wrAddr.rc.row <= pwdata[pixRowLsb +: sideBits];
               wrAddr.rc.col <= pwdata[pixColLsb +: sideBits];
               pixFrame      <= pwdata[pixFrameLsb +: frameSelWidth];
            end
            regPixData: wrAddr.linear <= wrAddr.linear + 1'b1; // col carries into row
            default: ;
         endcase
      end
   end

   assign animNext = animCount + 1'b1;

   always_ff @(posedge clk) begin
      if (rst) begin
         animCount <= '0;
         animFrame <= '0;
      end else if (!autoAnimate) begin
         animCount <= '0;
         animFrame <= frameSel;                     // animation starts from the manual frame
      end else if (frameStart) begin
         if (animNext >= period) begin              // period 0 acts as 1
            animCount <= '0;
            animFrame <= (animFrame + 1'b1) & frameSelWidth'(numFrames - 1);
         end else begin
            animCount <= animNext;
         end
      end
   end

   assign activeFrame = autoAnimate ? animFrame : frameSel;

   always_comb begin
      prdata = '0;
      case (paddr)
         regCtrl: begin
            prdata[ctrlEnBit]                     = enable;
            prdata[ctrlAutoBit]                   = autoAnimate;
            prdata[ctrlSelLsb +: frameSelWidth]   = frameSel;
            prdata[ctrlPeriodLsb +: periodWidth]  = period;
         end
         regPos: begin
            prdata[posXLsb +: posWidth] = posX;
            prdata[posYLsb +: posWidth] = posY;
         end
         regPixAddr: begin
            prdata[pixRowLsb +: sideBits]        = wrAddr.rc.row;
            prdata[pixColLsb +: sideBits]        = wrAddr.rc.col;
            prdata[pixFrameLsb +: frameSelWidth] = pixFrame;
         end
         default: prdata = '0;                      // pixel data and holes read zero
      endcase
   end

endmodule

`default_nettype wire

/* verilog/spriteEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module spriteEngine #(
   parameter int numFrames = 4   // power of two, at most 4
) (
   input  wire                                  clk,
   input  wire                                  rst,
   input  wire                                  psel,
   input  wire                                  penable,
   input  wire                                  pwrite,
   input  wire [spriteRegPkg::apbAddrBits-1:0]  paddr,
   input  wire [spriteRegPkg::apbDataBits-1:0]  pwdata,
   output wire [spriteRegPkg::apbDataBits-1:0]  prdata,
   output wire                                  pready,
   output wire                                  pslverr,
   input  wire [spriteGeomPkg::coordBits-1:0]   beamX,
   input  wire [spriteGeomPkg::coordBits-1:0]   beamY,
   input  wire                                  beamValid,
   input  wire                                  frameStart,
   output wire                                  pixelOn,
   output wire                                  pixelValid
);
   import spriteGeomPkg::*;
   import spriteRegPkg::*;

   logic [coordBits-1:0]     posX;
   logic [coordBits-1:0]     posY;
   logic                     enable;
   logic [frameSelWidth-1:0] activeFrame;
   pixelAddr_u               wrAddr;
   logic                     wrData;
   logic [numFrames-1:0]     wrEn;
   pixelAddr_u               rdAddr;
   logic                     rdEn;
   logic                     inBounds;
   logic                     scanValid;
   logic [numFrames-1:0]     framePixels;   // one bit from every frame store

   spriteApbRegs #(
      .numFrames (numFrames)
   ) uRegs (
      .clk         (clk),
      .rst         (rst),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .frameStart  (frameStart),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .posX        (posX),
      .posY        (posY),
      .enable      (enable),
      .activeFrame (activeFrame),
      .wrAddr      (wrAddr),
      .wrData      (wrData),
      .wrEn        (wrEn)
   );

   frameScanner uScanner (
      .clk       (clk),
      .rst       (rst),
      .beamX     (beamX),
      .beamY     (beamY),
      .beamValid (beamValid),
      .posX      (posX),
      .posY      (posY),
      .rdAddr    (rdAddr),
      .rdEn      (rdEn),
      .inBounds  (inBounds),
      .validOut  (scanValid)
   );

   // all frames read the same address, only the active one is used
   for (genvar f = 0; f < numFrames; f++) begin : frameGen
      frameStore uStore (
         .clk    (clk),
         .rdEn   (rdEn),
         .rdAddr (rdAddr),
         .wrEn   (wrEn[f]),
         .wrAddr (wrAddr),
         .wrData (wrData),
         .pixel  (framePixels[f])
      );
   end

   spriteOutput #(
      .numFrames (numFrames)
   ) uOutput (
      .clk         (clk),
      .rst         (rst),
      .framePixels (framePixels),
      .activeFrame (activeFrame),
      .enable      (enable),
      .inBounds    (inBounds),
      .validIn     (scanValid),
      .pixelOn     (pixelOn),
      .pixelValid  (pixelValid)
   );

endmodule

`default_nettype wire

/* bench/spriteTests.svh */
   function automatic logic [apbDataBits-1:0] ctrlWord(input logic en, input logic autoOn,
                                                       input int sel, input int per);
      logic [apbDataBits-1:0] w;
      w = '0;
      w[ctrlEnBit]                    = en;
      w[ctrlAutoBit]                  = autoOn;
      w[ctrlSelLsb +: frameSelWidth]  = frameSelWidth'(sel);
      w[ctrlPeriodLsb +: periodWidth] = periodWidth'(per);
      return w;
   endfunction

   function automatic logic [apbDataBits-1:0] posWord(input int x, input int y);
      logic [apbDataBits-1:0] w;
      w = '0;
      w[posXLsb +: posWidth] = posWidth'(x);
      w[posYLsb +: posWidth] = posWidth'(y);
      return w;
   endfunction

   function automatic logic [apbDataBits-1:0] pixAddrWord(input int frame, input int row,
                                                          input int col);
      logic [apbDataBits-1:0] w;
      w = '0;
      w[pixFrameLsb +: frameSelWidth] = frameSelWidth'(frame);
      w[pixRowLsb +: sideBits]        = sideBits'(row);
      w[pixColLsb +: sideBits]        = sideBits'(col);
      return w;
   endfunction

   // reference model is off outside the box or when disabled
   function automatic logic expectedPixel(input int frame, input logic en, input int px,
                                          input int py, input int x, input int y);
      int dx;
      int dy;
      dx = x - px;
      dy = y - py;
      if (!en || dx < 0 || dx >= spriteSide || dy < 0 || dy >= spriteSide) begin
         return 1'b0;
      end
      return shadow[frame][dy * spriteSide + dx];
   endfunction

   task automatic writeReg(input string name, input logic [apbAddrBits-1:0] addr,
                           input logic [apbDataBits-1:0] data);
      logic err;
      apbWrite(addr, data, err);
      checkBit({name, " pslverr"}, 1'b0, err);
   endtask

   task automatic writePixel(input int frame, input int row, input int col, input logic value);
      writeReg("pixel address", regPixAddr, pixAddrWord(frame, row, col));
      writeReg("pixel data", regPixData, apbDataBits'(value));
      shadow[frame][row * spriteSide + col] = value;
   endtask

   // fills a whole frame through the auto-incrementing address
   task automatic loadFrame(input int frame);
      int   a;
      logic pix;
      writeReg("load address", regPixAddr, pixAddrWord(frame, 0, 0));
      for (a = 0; a < frameDepth; a++) begin
         lfsrState = lfsrStep(lfsrState);
         pix = lfsrState[0];
         shadow[frame][a] = pix;
         writeReg("load data", regPixData, apbDataBits'(pix));
      end
   endtask

   task automatic queueRow(input int y, input int x0, input int x1);
      int x;
      for (x = x0; x <= x1; x++) begin
         scanX.push_back(x);
         scanY.push_back(y);
      end
   endtask

   // back-to-back beam samples with each result checked 3 cycles later
   task automatic scanQueued(input string name, input int frame, input logic en,
                             input int px, input int py);
      int    n;
      int    i;
      int    k;
      string tag;
      n = scanX.size();
      for (i = 0; i < n + 4; i++) begin
         @(posedge clk);
         if (i < n) begin
            beamX     <= coordBits'(scanX[i]);
            beamY     <= coordBits'(scanY[i]);
            beamValid <= 1'b1;
         end else begin
            beamValid <= 1'b0;
         end
         @(negedge clk);
         k = i - 3;
         if (k >= n) begin
            checkBit({name, " valid after scan"}, 1'b0, pixelValid);
            checkBit({name, " pixel after scan"}, 1'b0, pixelOn);
         end else if (k >= 0) begin
            tag = $sformatf("%s at (%0d,%0d)", name, scanX[k], scanY[k]);
            checkBit({tag, " valid"}, 1'b1, pixelValid);
            checkBit(tag, expectedPixel(frame, en, px, py, scanX[k], scanY[k]), pixelOn);
         end
      end
      scanX.delete();
      scanY.delete();
   endtask

   task automatic registerTest;
      logic [apbDataBits-1:0] rd;
      logic                   err;
      checkBit("reset pixelValid", 1'b0, pixelValid);
      checkBit("reset pixelOn", 1'b0, pixelOn);
      apbRead(regCtrl, rd, err);
      checkWord("reset ctrl", '0, rd);
      apbRead(regPos, rd, err);
      checkWord("reset pos", '0, rd);
      apbRead(regPixAddr, rd, err);
      checkWord("reset pixAddr", '0, rd);
      checkBit("reset read pslverr", 1'b0, err);
      // stray bits outside the fields must not read back
      writeReg("ctrl", regCtrl, 32'hA5C3_00CC | ctrlWord(1'b1, 1'b0, 2, 8'h5A));
      apbRead(regCtrl, rd, err);
      checkWord("ctrl readback", ctrlWord(1'b1, 1'b0, 2, 8'h5A), rd);
      writeReg("pos", regPos, 32'hFC00_FC00 | posWord(10'h155, 10'h02A));
      apbRead(regPos, rd, err);
      checkWord("pos readback", posWord(10'h155, 10'h02A), rd);
      writeReg("pixAddr", regPixAddr, 32'hFFFC_C000 | pixAddrWord(3, 7'h55, 7'h2B));
      apbRead(regPixAddr, rd, err);
      checkWord("pixAddr readback", pixAddrWord(3, 7'h55, 7'h2B), rd);
      writeReg("pixData", regPixData, 32'h1);
      shadow[3][7'h55 * spriteSide + 7'h2B] = 1'b1;
      apbRead(regPixData, rd, err);
      checkWord("pixData reads zero", '0, rd);
      apbRead(regPixAddr, rd, err);
      checkWord("pixAddr increment", pixAddrWord(3, 7'h55, 7'h2C), rd);
      writePixel(0, 5, spriteSide - 1, 1'b0);
      apbRead(regPixAddr, rd, err);
      checkWord("pixAddr column wrap", pixAddrWord(0, 6, 0), rd);
      apbRead(8'h10, rd, err);
      checkBit("unmapped read pslverr", 1'b1, err);
      apbWrite(8'h14, 32'hFFFF_FFFF, err);
      checkBit("unmapped write pslverr", 1'b1, err);
      apbRead(regCtrl, rd, err);
      checkWord("ctrl after errors", ctrlWord(1'b1, 1'b0, 2, 8'h5A), rd);
      writeReg("ctrl clear", regCtrl, '0);
      writeReg("pos clear", regPos, '0);
   endtask

   task automatic loadScanTest;
      int y;
      writeReg("origin", regPos, posWord(0, 0));
      writeReg("enable", regCtrl, ctrlWord(1'b1, 1'b0, 0, 0));
      loadFrame(0);
      loadFrame(1);
      for (y = 0; y < spriteSide; y++) begin
         queueRow(y, 0, spriteSide - 1);
      end
      scanQueued("full scan frame 0", 0, 1'b1, 0, 0);
   endtask

   task automatic boundsTest;
      int dy;
      int pass;
      writeReg("bounds pos", regPos, posWord(300, 200));
      for (pass = 0; pass < 2; pass++) begin
         writeReg("bounds ctrl", regCtrl, ctrlWord(pass == 0, 1'b0, 0, 0));
         for (dy = -2; dy <= spriteSide + 1; dy++) begin
            if (dy <= 1 || dy == spriteSide / 2 || dy >= spriteSide - 2) begin
               queueRow(200 + dy, 296, 300 + spriteSide + 3);
            end
         end
         scanQueued(pass == 0 ? "bounds enabled" : "bounds disabled", 0, pass == 0, 300, 200);
      end
      // box runs past the right edge of the coordinate range
      writeReg("wrap pos", regPos, posWord(1000, 0));
      writeReg("wrap ctrl", regCtrl, ctrlWord(1'b1, 1'b0, 1, 0));
      queueRow(0, 996, 1023);
      queueRow(0, 0, 5);
      queueRow(spriteSide - 1, 996, 1023);
      queueRow(spriteSide, 996, 1023);
      scanQueued("bounds wrap", 1, 1'b1, 1000, 0);
   endtask

   task automatic frameSelectTest;
      int step;
      int sel;
      writeReg("select pos", regPos, posWord(0, 0));
      for (step = 0; step < 3; step++) begin
         sel = (step == 1) ? 0 : 1;
         writeReg("select ctrl", regCtrl, ctrlWord(1'b1, 1'b0, sel, 0));
         queueRow(10, 0, spriteSide - 1);
         queueRow(77, 0, spriteSide - 1);
         scanQueued($sformatf("frame select %0d", sel), sel, 1'b1, 0, 0);
      end
   endtask

   task automatic animationTest;
      int f;
      int step;
      int period;
      int count;
      int frame;
      // two pixels per frame spell out the frame index
      for (f = 0; f < numFrames; f++) begin
         writePixel(f, 9, 40, f[0]);
         writePixel(f, 9, 41, f[1]);
      end
      period = 2;
      count  = 0;
      frame  = 0;
      writeReg("anim manual", regCtrl, ctrlWord(1'b1, 1'b0, 0, period));
      writeReg("anim start", regCtrl, ctrlWord(1'b1, 1'b1, 0, period));
      for (step = 0; step < 14; step++) begin
         if (step == 10) begin
            period = 0;
            writeReg("anim period 0", regCtrl, ctrlWord(1'b1, 1'b1, 0, period));
         end
         if (step > 0) begin
            @(posedge clk);
            frameStart <= 1'b1;
            @(posedge clk);
            frameStart <= 1'b0;
            count++;
            if (count >= (period == 0 ? 1 : period)) begin
               count = 0;
               frame = (frame + 1) % numFrames;
            end
         end
         queueRow(9, 40, 41);
         scanQueued($sformatf("animation step %0d", step), frame, 1'b1, 0, 0);
      end
      writeReg("anim stop", regCtrl, '0);
   endtask

/* bench/spriteEngineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module spriteEngineTb;
   import spriteGeomPkg::*;
   import spriteRegPkg::*;

   localparam int numFrames     = 4;
   localparam int loadCycles    = 3 * (frameDepth + 2);   // one frame through regPixData
   localparam int windowPoints  = 136 * 9 * 2 + 34 * 4;
   localparam int testCycles    = 2 * loadCycles + frameDepth + 8 + 3 * windowPoints + 4096;
   localparam int timeoutCycles = 4 * testCycles;

   logic                   clk;
   logic                   rst;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [apbAddrBits-1:0] paddr;
   logic [apbDataBits-1:0] pwdata;
   wire  [apbDataBits-1:0] prdata;
   wire                    pready;
   wire                    pslverr;
   logic [coordBits-1:0]   beamX;
   logic [coordBits-1:0]   beamY;
   logic                   beamValid;
   logic                   frameStart;
   wire                    pixelOn;
   wire                    pixelValid;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [31:0] lfsrState;
   logic        shadow [numFrames][frameDepth];   // reference copy of every frame store
   int          scanX [$];
   int          scanY [$];

   spriteEngine #(
      .numFrames (numFrames)
   ) dut0 (
      .clk        (clk),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .beamX      (beamX),
      .beamY      (beamY),
      .beamValid  (beamValid),
      .frameStart (frameStart),
      .pixelOn    (pixelOn),
      .pixelValid (pixelValid)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeoutCycles) begin
         $display("Timeout: run did not finish within %0d cycles (%0d checks, %0d errors)",
                  timeoutCycles, checks, errors);
         $display("Checks failed");
         $finish;
      end
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic checkBit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic checkWord(input string name, input logic [apbDataBits-1:0] expected,
                            input logic [apbDataBits-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      end
   endtask

   task automatic reportError(input string what);
      errors++;
      $display("Error: %s", what);
   endtask

   // setup cycle and access cycle, then the bus goes idle for a cycle
   task automatic apbWrite(input logic [apbAddrBits-1:0] addr,
                           input logic [apbDataBits-1:0] data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      if (pready !== 1'b1) begin
         reportError($sformatf("pready was low in the access cycle of a write to 0x%02h", addr));
      end
      err = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apbRead(input logic [apbAddrBits-1:0] addr,
                          output logic [apbDataBits-1:0] data, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      if (pready !== 1'b1) begin
         reportError($sformatf("pready was low in the access cycle of a read from 0x%02h", addr));
      end
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   `include "spriteTests.svh"

   initial begin
      rst        = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      beamX      = '0;
      beamY      = '0;
      beamValid  = 1'b0;
      frameStart = 1'b0;
      lfsrState  = 32'h7659_a15b;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      registerTest();
      loadScanTest();
      boundsTest();
      frameSelectTest();
      animationTest();
      repeat (2) @(posedge clk);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
verilog/spriteGeomPkg.sv
verilog/spriteRegPkg.sv
verilog/frameStore.sv
verilog/frameScanner.sv
verilog/spriteOutput.sv
verilog/spriteApbRegs.sv
verilog/spriteEngine.sv
bench/spriteEngineTb.sv

/* Bender.yml */
package:
  name: spriteEngine

sources:
  - files:
      - verilog/spriteGeomPkg.sv
      - verilog/spriteRegPkg.sv
      - verilog/frameStore.sv
      - verilog/frameScanner.sv
      - verilog/spriteOutput.sv
      - verilog/spriteApbRegs.sv
      - verilog/spriteEngine.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/spriteEngineTb.sv
